// ==== run_sim.sh ====
#!/bin/sh
# Build and run the synthesizer testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module synth_tb \
    -Mdir obj_dir -o synth_sim > build.log 2>&1 \
    && ./obj_dir/synth_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1
grep -q "RESULT: PASS" sim.log && exit 0 || exit 1

// ==== src/dds_voice.sv ====
// DDS voice with phase accumulator, quarter-wave sine, velocity scaling and fade envelope
`timescale 1ns/1ns

module dds_voice
    import synth_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sample_tick,
    input  note_cmd_t  note_cmd,
    output voice_out_t voice_out
);

    logic [SAMPLE_W-1:0]          sine_rom [2**QSINE_AW];

    logic [PHASE_W-1:0]           phase_q;
    logic [PHASE_W-1:0]           tuning_q;
    logic [VEL_W-1:0]             velocity_q;
    logic [DUR_W-1:0]             elapsed_q;
    logic [DUR_W-1:0]             remaining_q;
    logic                         active_q;
    logic signed [SAMPLE_W-1:0]   sample_q;

    env_state_e                   env_state;
    logic [1:0]                   quadrant;
    logic [QSINE_AW-1:0]          rom_idx;
    logic signed [SAMPLE_W-1:0]   sine_val;
    logic signed [SAMPLE_W+VEL_W:0] vel_prod;
    logic signed [SAMPLE_W-1:0]   vel_scaled;
    logic [FADE_SHIFT-1:0]        fade_gain;
    logic signed [SAMPLE_W+FADE_SHIFT:0] fade_prod;
    logic signed [SAMPLE_W-1:0]   env_sample;

    initial begin
        $readmemh("src/quarter_sine.hex", sine_rom);
    end

    // ========================================
    // Waveform path
    // ========================================
    assign quadrant = phase_q[PHASE_W-1 -: 2];
    // Odd quadrants walk the table backwards, 63 minus index
    assign rom_idx  = quadrant[0] ? ~phase_q[PHASE_W-3 -: QSINE_AW]
                                  : phase_q[PHASE_W-3 -: QSINE_AW];
    assign sine_val = quadrant[1] ? -$signed(sine_rom[rom_idx]) : $signed(sine_rom[rom_idx]);

    assign vel_prod   = sine_val * $signed({1'b0, velocity_q});
    assign vel_scaled = SAMPLE_W'(vel_prod >>> (VEL_W - 1));  // 127 is near unity

    always_comb begin
        if (!active_q) begin
            env_state = IDLE;
        end else if (elapsed_q < FADE_SAMPLES) begin
            env_state = FADE_IN;
        end else if (remaining_q < FADE_SAMPLES) begin
            env_state = FADE_OUT;
        end else begin
            env_state = HOLD;
        end
    end

    always_comb begin
        case (env_state)
            FADE_IN:  fade_gain = elapsed_q[FADE_SHIFT-1:0];
            FADE_OUT: fade_gain = remaining_q[FADE_SHIFT-1:0];
            default:  fade_gain = '0;
        endcase
        fade_prod = vel_scaled * $signed({1'b0, fade_gain});
        case (env_state)
            FADE_IN, FADE_OUT: env_sample = SAMPLE_W'(fade_prod >>> FADE_SHIFT);
            HOLD:              env_sample = vel_scaled;
            default:           env_sample = '0;
        endcase
    end

    // ========================================
    // Note sequencing
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_q     <= '0;
            elapsed_q   <= '0;
            remaining_q <= '0;
            active_q    <= 1'b0;
            sample_q    <= '0;
        end else if (note_cmd.start) begin  // Restart wins over a tick
            phase_q     <= '0;
            elapsed_q   <= '0;
            remaining_q <= note_cmd.duration;
            active_q    <= 1'b1;
            sample_q    <= '0;
        end else if (sample_tick) begin
            if (active_q && remaining_q != '0) begin
                sample_q    <= env_sample;
                phase_q     <= phase_q + tuning_q;
                elapsed_q   <= elapsed_q + 1'b1;
                remaining_q <= remaining_q - 1'b1;
            end else begin
                active_q    <= 1'b0;  // Duration spent
                sample_q    <= '0;
            end
        end
    end

    // Tuning and velocity are held for the whole note
    always_ff @(posedge clk) begin
        if (note_cmd.start) begin
            tuning_q   <= note_cmd.tuning;
            velocity_q <= note_cmd.velocity;
        end
    end

    assign voice_out = '{sample: sample_q, active: active_q};

endmodule

// ==== src/note_register_bank.sv ====
// AXI4-Lite register bank holding per-voice note settings and issuing note starts
`timescale 1ns/1ns

module note_register_bank
    import synth_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  axil_req_t             axil_req,
    output axil_rsp_t             axil_rsp,
    input  logic [NUM_VOICES-1:0] voice_active,
    input  logic [DATA_W-1:0]     sample_count,
    output note_cmd_t             note_cmd [NUM_VOICES]
);

    logic [PHASE_W-1:0]     tuning_q   [NUM_VOICES];
    logic [DUR_W-1:0]       duration_q [NUM_VOICES];
    logic [VEL_W-1:0]       velocity_q [NUM_VOICES];
    logic [NUM_VOICES-1:0]  start_q;

    logic                   aw_w_ready_q;  // Shared by awready and wready
    logic                   bvalid_q;
    axi_resp_e              bresp_q;
    logic                   arready_q;
    logic                   rvalid_q;
    logic [DATA_W-1:0]      rdata_q;
    axi_resp_e              rresp_q;

    logic [VOICE_IDX_W-1:0] wr_voice, rd_voice;
    reg_offset_e            wr_offset, rd_offset;
    logic                   wr_in_voice, rd_in_voice;
    logic                   wr_fire, rd_fire, wr_hit;
    logic [DATA_W-1:0]      wr_cur, wr_merged, rd_data;
    axi_resp_e              rd_resp;

    function automatic logic [DATA_W-1:0] apply_strobe(input logic [DATA_W-1:0]   cur,
                                                       input logic [DATA_W-1:0]   data,
                                                       input logic [DATA_W/8-1:0] strb);
        logic [DATA_W-1:0] res;
        res = cur;
        for (int b = 0; b < DATA_W / 8; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    // ========================================
    // Address decode
    // ========================================
    assign wr_voice    = axil_req.awaddr[OFFSET_W +: VOICE_IDX_W];
    assign wr_offset   = reg_offset_e'(axil_req.awaddr[OFFSET_W-1:0]);
    assign wr_in_voice = (axil_req.awaddr[ADDR_W-1:OFFSET_W+VOICE_IDX_W] == '0);
    assign rd_voice    = axil_req.araddr[OFFSET_W +: VOICE_IDX_W];
    assign rd_offset   = reg_offset_e'(axil_req.araddr[OFFSET_W-1:0]);
    assign rd_in_voice = (axil_req.araddr[ADDR_W-1:OFFSET_W+VOICE_IDX_W] == '0);

    assign wr_fire = aw_w_ready_q && axil_req.awvalid && axil_req.wvalid;
    assign rd_fire = arready_q && axil_req.arvalid;

    always_comb begin
        wr_hit = wr_in_voice;
        wr_cur = '0;
        case (wr_offset)
            REG_TUNING:   wr_cur = tuning_q[wr_voice];
            REG_DURATION: wr_cur = DATA_W'(duration_q[wr_voice]);
            REG_CONTROL:  wr_cur = DATA_W'(velocity_q[wr_voice]);
            default:      wr_hit = 1'b0;  // Offset 0xC and unaligned
        endcase
        wr_merged = apply_strobe(wr_cur, axil_req.wdata, axil_req.wstrb);
    end

    always_comb begin
        rd_data = '0;
        rd_resp = OKAY;
        if (rd_in_voice) begin
            case (rd_offset)
                REG_TUNING:   rd_data = tuning_q[rd_voice];
                REG_DURATION: rd_data = DATA_W'(duration_q[rd_voice]);
                REG_CONTROL:  rd_data = DATA_W'(velocity_q[rd_voice]);
                default:      rd_resp = SLVERR;
            endcase
        end else if (axil_req.araddr == STATUS_ADDR) begin
            rd_data = DATA_W'(voice_active);
        end else if (axil_req.araddr == COUNT_ADDR) begin
            rd_data = sample_count;
        end else begin
            rd_resp = SLVERR;
        end
    end

    // ========================================
    // Handshake and start pulses
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_w_ready_q <= 1'b0;
            bvalid_q     <= 1'b0;
            bresp_q      <= OKAY;
            arready_q    <= 1'b0;
            rvalid_q     <= 1'b0;
            rresp_q      <= OKAY;
            start_q      <= '0;
        end else begin
            aw_w_ready_q <= !aw_w_ready_q && axil_req.awvalid && axil_req.wvalid && !bvalid_q;
            arready_q    <= !arready_q && axil_req.arvalid && !rvalid_q;
            start_q      <= '0;
            if (wr_fire) begin
                bvalid_q <= 1'b1;
                bresp_q  <= wr_hit ? OKAY : SLVERR;
                if (wr_hit && wr_offset == REG_CONTROL) begin
                    start_q[wr_voice] <= 1'b1;
                end
            end else if (axil_req.bready) begin
                bvalid_q <= 1'b0;
            end
            if (rd_fire) begin
                rvalid_q <= 1'b1;
                rresp_q  <= rd_resp;
            end else if (axil_req.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // Note settings and read data
    always_ff @(posedge clk) begin
        if (wr_fire && wr_hit) begin
            case (wr_offset)
                REG_TUNING:   tuning_q[wr_voice]   <= wr_merged;
                REG_DURATION: duration_q[wr_voice] <= wr_merged[DUR_W-1:0];
                default:      velocity_q[wr_voice] <= wr_merged[VEL_W-1:0];
            endcase
        end
        if (rd_fire) begin
            rdata_q <= rd_data;
        end
    end

    always_comb begin
        for (int v = 0; v < NUM_VOICES; v++) begin
            note_cmd[v] = '{tuning:   tuning_q[v],
                            duration: duration_q[v],
                            velocity: velocity_q[v],
                            start:    start_q[v]};
        end
    end

    assign axil_rsp = '{awready: aw_w_ready_q,
                        wready:  aw_w_ready_q,
                        bvalid:  bvalid_q,
                        bresp:   bresp_q,
                        arready: arready_q,
                        rvalid:  rvalid_q,
                        rdata:   rdata_q,
                        rresp:   rresp_q};

endmodule

// ==== src/quarter_sine.hex ====
// Quarter-wave sine magnitude, one 16-bit word per index 0 to 63
0192
04B6
07D9
0AFB
0E1C
113A
1455
176E
1A82
1D93
209F
23A6
26A8
29A3
2C99
2F87
326E
354D
3824
3AF2
3DB8
4073
4325
45CD
4869
4AFB
4D81
4FFB
5268
54C9
571D
5964
5B9C
5DC7
5FE3
61F0
63EE
65DD
67BC
698B
6B4A
6CF8
6E96
7022
719D
7307
745F
75A5
76D9
77FA
7909
7A05
7AEF
7BC5
7C88
7D38
7DD5
7E5F
7ED5
7F37
7F86
7FC1
7FE9
7FFD

// ==== src/sample_clock.sv ====
// Clock divider issuing the sample tick and keeping the running sample count
`timescale 1ns/1ns

module sample_clock
    import synth_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    output logic              sample_tick,
    output logic [DATA_W-1:0] sample_count
);

    logic [$clog2(CLOCK_DIV)-1:0] div_cnt;

    // First tick lands CLOCK_DIV cycles after reset release
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt      <= '0;
            sample_tick  <= 1'b0;
            sample_count <= '0;
        end else if (div_cnt == $clog2(CLOCK_DIV)'(CLOCK_DIV - 1)) begin
            div_cnt      <= '0;
            sample_tick  <= 1'b1;
            sample_count <= sample_count + 1'b1;  // Counts ticks as issued
        end else begin
            div_cnt      <= div_cnt + 1'b1;
            sample_tick  <= 1'b0;
        end
    end

endmodule

// ==== src/synth_pkg.sv ====
// Shared widths, register map, bus and voice types for the four-voice DDS synthesizer
package synth_pkg;

    // ========================================
    // Sizes
    // ========================================
    localparam int NUM_VOICES   = 4;
    localparam int VOICE_IDX_W  = 2;
    localparam int PHASE_W      = 32;  // Accumulator and tuning word
    localparam int SAMPLE_W     = 16;
    localparam int DUR_W        = 16;  // Duration in samples
    localparam int VEL_W        = 8;   // Useful range 0 to 127
    localparam int CLOCK_DIV    = 16;  // Clocks per sample tick
    localparam int FADE_SHIFT   = 6;
    localparam int FADE_SAMPLES = 64;
    localparam int MIX_SHIFT    = 2;   // log2 of NUM_VOICES
    localparam int QSINE_AW     = 6;   // Quarter-wave table index width

    // ========================================
    // Bus and register map
    // ========================================
    localparam int ADDR_W       = 8;
    localparam int DATA_W       = 32;
    localparam int VOICE_STRIDE = 16;  // Bytes per voice block
    localparam int OFFSET_W     = $clog2(VOICE_STRIDE);

    localparam logic [ADDR_W-1:0] STATUS_ADDR = 8'h40;
    localparam logic [ADDR_W-1:0] COUNT_ADDR  = 8'h44;

    typedef enum logic [OFFSET_W-1:0] {
        REG_TUNING   = 'h0,
        REG_DURATION = 'h4,
        REG_CONTROL  = 'h8   // Velocity in 7:0, write starts the note
    } reg_offset_e;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

    typedef enum logic [1:0] {
        IDLE,
        FADE_IN,
        HOLD,
        FADE_OUT
    } env_state_e;

    // Master-driven AXI4-Lite signals
    typedef struct packed {
        logic                  awvalid;
        logic [ADDR_W-1:0]     awaddr;
        logic                  wvalid;
        logic [DATA_W-1:0]     wdata;
        logic [DATA_W/8-1:0]   wstrb;
        logic                  bready;
        logic                  arvalid;
        logic [ADDR_W-1:0]     araddr;
        logic                  rready;
    } axil_req_t;

    // Slave-driven AXI4-Lite signals
    typedef struct packed {
        logic                  awready;
        logic                  wready;
        logic                  bvalid;
        axi_resp_e             bresp;
        logic                  arready;
        logic                  rvalid;
        logic [DATA_W-1:0]     rdata;
        axi_resp_e             rresp;
    } axil_rsp_t;

    typedef struct packed {
        logic [PHASE_W-1:0]    tuning;
        logic [DUR_W-1:0]      duration;
        logic [VEL_W-1:0]      velocity;
        logic                  start;     // One-cycle pulse
    } note_cmd_t;

    typedef struct packed {
        logic signed [SAMPLE_W-1:0] sample;
        logic                       active;
    } voice_out_t;

endpackage

// ==== src/synth_top.sv ====
// Top level of the four-voice DDS tone generator with AXI4-Lite control
`timescale 1ns/1ns

module synth_top
    import synth_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  axil_req_t                  axil_req,
    output axil_rsp_t                  axil_rsp,
    output logic signed [SAMPLE_W-1:0] audio_out,
    output logic                       sample_valid,
    output logic [DATA_W-1:0]          sample_count
);

    logic                  sample_tick;
    logic [NUM_VOICES-1:0] voice_active;  // Feeds the STATUS register
    note_cmd_t             note_cmd  [NUM_VOICES];
    voice_out_t            voice_out [NUM_VOICES];

    note_register_bank u_bank (
        .clk          (clk),
        .rst_n        (rst_n),
        .axil_req     (axil_req),
        .axil_rsp     (axil_rsp),
        .voice_active (voice_active),
        .sample_count (sample_count),
        .note_cmd     (note_cmd)
    );

    sample_clock u_sample_clock (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_tick  (sample_tick),
        .sample_count (sample_count)
    );

    for (genvar v = 0; v < NUM_VOICES; v++) begin : g_voice
        dds_voice u_voice (
            .clk         (clk),
            .rst_n       (rst_n),
            .sample_tick (sample_tick),
            .note_cmd    (note_cmd[v]),
            .voice_out   (voice_out[v])
        );
        assign voice_active[v] = voice_out[v].active;
    end

    voice_mixer u_mixer (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_tick  (sample_tick),
        .voice_out    (voice_out),
        .audio_out    (audio_out),
        .sample_valid (sample_valid)
    );

endmodule

// ==== src/voice_mixer.sv ====
// Mixer summing the voice samples and registering the scaled audio output
`timescale 1ns/1ns

module voice_mixer
    import synth_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       sample_tick,
    input  voice_out_t                 voice_out [NUM_VOICES],
    output logic signed [SAMPLE_W-1:0] audio_out,
    output logic                       sample_valid
);

    logic                                  tick_d;  // Lines up with voice outputs
    logic signed [SAMPLE_W+MIX_SHIFT-1:0]  mix_sum;

    // Headroom of MIX_SHIFT bits covers the full voice count
    always_comb begin
        mix_sum = '0;
        for (int v = 0; v < NUM_VOICES; v++) begin
            mix_sum = mix_sum + voice_out[v].sample;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_d       <= 1'b0;
            sample_valid <= 1'b0;
            audio_out    <= '0;
        end else begin
            tick_d       <= sample_tick;
            sample_valid <= tick_d;
            if (tick_d) begin
                audio_out <= SAMPLE_W'(mix_sum >>> MIX_SHIFT);
            end
        end
    end

endmodule

// ==== tb.f ====
src/synth_pkg.sv
src/note_register_bank.sv
src/sample_clock.sv
src/dds_voice.sv
src/voice_mixer.sv
src/synth_top.sv
verification/synth_tb_sva.sv
verification/synth_tb.sv

// ==== verification/synth_tb.sv ====
// Directed testbench for the DDS tone generator with a cycle-level voice model
`timescale 1ns/1ns

module synth_tb
    import synth_pkg::*;
();

    localparam int SAMPLE_BUDGET = 1000;  // Samples used by all tests together
    localparam longint WATCHDOG_NS = 2 * SAMPLE_BUDGET * CLOCK_DIV * 8;

    logic clk = 1'b0;
    logic rst_n;
    axil_req_t req;
    axil_rsp_t rsp;
    logic signed [SAMPLE_W-1:0] audio_out;
    logic sample_valid;
    logic [DATA_W-1:0] sample_count;

    int errors = 0;
    int samples_checked = 0;
    int valid_count = 0;

    // Reference model state
    logic [SAMPLE_W-1:0] rom [64];
    logic [PHASE_W-1:0] sh_tun [NUM_VOICES];
    logic [DUR_W-1:0] sh_dur [NUM_VOICES];
    logic [VEL_W-1:0] sh_vel [NUM_VOICES];
    logic [PHASE_W-1:0] m_phase [NUM_VOICES];
    logic [PHASE_W-1:0] m_tun [NUM_VOICES];
    logic [VEL_W-1:0] m_vel [NUM_VOICES];
    logic [DUR_W-1:0] m_el [NUM_VOICES];
    logic [DUR_W-1:0] m_rem [NUM_VOICES];
    logic [NUM_VOICES-1:0] m_act, m_start;
    int m_smp [NUM_VOICES];
    int m_div, exp_audio;
    logic m_tick, m_tick_d;
    logic exp_valid;
    logic [DATA_W-1:0] exp_count;

    always #4 clk = ~clk;

    synth_top UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .axil_req     (req),
        .axil_rsp     (rsp),
        .audio_out    (audio_out),
        .sample_valid (sample_valid),
        .sample_count (sample_count)
    );

    bind synth_top synth_tb_sva u_sva (
        .clk          (clk),
        .rst_n        (rst_n),
        .axil_req     (axil_req),
        .axil_rsp     (axil_rsp),
        .sample_tick  (sample_tick),
        .voice_active (voice_active),
        .sample_valid (sample_valid),
        .audio_out    (audio_out)
    );

    initial $readmemh("src/quarter_sine.hex", rom);

    // ========================================
    // Reference model
    // ========================================
    function automatic int voice_sample(input logic [PHASE_W-1:0] phase, input int vel,
                                        input int el, input int rem);
        logic [1:0] quad;
        int idx;
        int s;
        quad = phase[31:30];
        idx = int'(phase[29:24]);
        if (quad[0]) idx = 63 - idx;  // Mirror in odd quadrants
        s = int'(rom[idx]);
        if (quad[1]) s = -s;
        s = (s * vel) >>> 7;
        if (el < FADE_SAMPLES) s = (s * el) >>> FADE_SHIFT;
        else if (rem < FADE_SAMPLES) s = (s * rem) >>> FADE_SHIFT;
        return s;
    endfunction

    always @(posedge clk or negedge rst_n) begin : voice_model
        int sum;
        int v;
        if (!rst_n) begin
            m_div <= 0;
            m_tick <= 1'b0;
            m_tick_d <= 1'b0;
            exp_audio <= 0;
            exp_valid <= 1'b0;
            exp_count <= '0;
            m_act <= '0;
            m_start <= '0;
            for (int i = 0; i < NUM_VOICES; i++) m_smp[i] <= 0;
        end else begin
            m_div <= (m_div == CLOCK_DIV - 1) ? 0 : m_div + 1;
            m_tick <= (m_div == CLOCK_DIV - 1);
            m_tick_d <= m_tick;
            exp_valid <= m_tick_d;
            if (m_div == CLOCK_DIV - 1) begin
                exp_count <= exp_count + 1'b1;  // Counted as the tick is issued
            end
            if (m_tick_d) begin
                sum = 0;
                for (int i = 0; i < NUM_VOICES; i++) sum += m_smp[i];
                exp_audio <= sum >>> MIX_SHIFT;
            end
            for (int i = 0; i < NUM_VOICES; i++) begin
                if (m_start[i]) begin  // Start beats a tick
                    m_phase[i] <= '0;
                    m_el[i] <= '0;
                    m_rem[i] <= sh_dur[i];
                    m_act[i] <= 1'b1;
                    m_smp[i] <= 0;
                    m_tun[i] <= sh_tun[i];
                    m_vel[i] <= sh_vel[i];
                end else if (m_tick) begin
                    if (m_act[i] && m_rem[i] != '0) begin
                        m_smp[i] <= voice_sample(m_phase[i], m_vel[i], m_el[i], m_rem[i]);
                        m_phase[i] <= m_phase[i] + m_tun[i];
                        m_el[i] <= m_el[i] + 1'b1;
                        m_rem[i] <= m_rem[i] - 1'b1;
                    end else begin
                        m_act[i] <= 1'b0;
                        m_smp[i] <= 0;
                    end
                end
            end
            m_start <= '0;
            // Mirror accepted register writes
            if (req.awvalid && req.wvalid && rsp.awready && req.awaddr[7:6] == 2'b00) begin
                v = int'(req.awaddr[5:4]);
                case (req.awaddr[3:0])
                    4'h0: sh_tun[v] <= req.wdata;
                    4'h4: sh_dur[v] <= req.wdata[DUR_W-1:0];
                    4'h8: begin
                        sh_vel[v] <= req.wdata[VEL_W-1:0];
                        m_start[v] <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            check_value("sample_valid", int'(exp_valid), int'(sample_valid));
            check_word("sample_count", exp_count, sample_count);
            if (sample_valid) begin
                valid_count++;
                samples_checked++;
                check_value("audio_out", exp_audio, int'(audio_out));
            end
        end
    end

    // ========================================
    // Checks and bus tasks
    // ========================================
    task automatic check_value(input string name, input int exp, input int act);
        assert (exp == act) else begin
            $display("FAIL t=%0t %s expected %0d got %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("FAIL t=%0t %s expected 0x%08h got 0x%08h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic start_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        @(negedge clk);
        req.awvalid = 1'b1;
        req.awaddr = addr;
        req.wvalid = 1'b1;
        req.wdata = data;
        req.wstrb = 4'hF;
    endtask

    task automatic wait_write_accept();
        @(negedge clk);
        while (!rsp.awready) @(negedge clk);
        @(negedge clk);  // Handshake done at the edge just passed
        req.awvalid = 1'b0;
        req.wvalid = 1'b0;
    endtask

    task automatic take_response(input int stall, output axi_resp_e resp);
        repeat (stall) begin
            assert (rsp.bvalid) else begin
                $display("Write response was lost while bready was held low");
                errors++;
            end
            @(negedge clk);
        end
        assert (rsp.bvalid) else begin
            $display("No write response after the write was accepted");
            errors++;
        end
        resp = rsp.bresp;
        req.bready = 1'b1;
        @(negedge clk);
        req.bready = 1'b0;
    endtask

    task automatic axil_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                              output axi_resp_e resp);
        start_write(addr, data);
        wait_write_accept();
        take_response(int'($urandom % 3), resp);
    endtask

    task automatic axil_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                             output axi_resp_e resp);
        @(negedge clk);
        req.arvalid = 1'b1;
        req.araddr = addr;
        @(negedge clk);
        while (!rsp.arready) @(negedge clk);
        @(negedge clk);
        req.arvalid = 1'b0;
        repeat ($urandom % 3) @(negedge clk);  // rready stall
        assert (rsp.rvalid) else begin
            $display("No read response after the read was accepted");
            errors++;
        end
        data = rsp.rdata;
        resp = rsp.rresp;
        req.rready = 1'b1;
        @(negedge clk);
        req.rready = 1'b0;
    endtask

    task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        axi_resp_e resp;
        axil_write(addr, data, resp);
        check_value("bresp", OKAY, resp);
    endtask

    task automatic read_reg(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        axi_resp_e resp;
        axil_read(addr, data, resp);
        check_value("rresp", OKAY, resp);
    endtask

    task automatic wait_samples(input int n);
        repeat (n) begin
            do @(negedge clk); while (!sample_valid);
        end
    endtask

    task automatic wait_idle();
        logic [31:0] st;
        int polls;
        st = 32'h1;
        polls = 0;
        while (st != 0 && polls < 300) begin
            wait_samples(1);
            read_reg(STATUS_ADDR, st);
            polls++;
        end
        assert (st == 0) else begin
            $display("Voices still playing after the polling limit");
            errors++;
        end
    endtask

    // ========================================
    // Tests
    // ========================================
    task automatic test_reset_readback();
        logic [31:0] d;
        read_reg(STATUS_ADDR, d);
        check_word("status", 32'h0, d);
        write_reg(8'h20, 32'h1234_5678);
        write_reg(8'h24, 32'h0000_0021);
        write_reg(8'h28, 32'h0000_0055);
        read_reg(8'h20, d);
        check_word("tuning2", 32'h1234_5678, d);
        read_reg(8'h24, d);
        check_word("duration2", 32'h0000_0021, d);
        read_reg(8'h28, d);
        check_word("control2", 32'h0000_0055, d);
        wait_idle();
    endtask

    task automatic test_single_voice();
        logic [31:0] d;
        write_reg(8'h00, $urandom);
        write_reg(8'h04, 32'd200);
        write_reg(8'h08, 32'd127);
        wait_samples(10);
        read_reg(STATUS_ADDR, d);
        check_word("status", 32'h1, d);
        wait_idle();
    endtask

    task automatic test_note_end();
        logic [31:0] d;
        write_reg(8'h10, $urandom);
        write_reg(8'h14, 32'd80);
        write_reg(8'h18, 32'd100);
        wait_samples(85);
        read_reg(STATUS_ADDR, d);
        check_word("status", 32'h0, d);
        write_reg(8'h14, 32'd150);
        write_reg(8'h18, 32'd100);
        wait_samples(30);
        write_reg(8'h18, 32'd90);  // Restart mid-note from phase zero
        wait_samples(20);
        read_reg(STATUS_ADDR, d);
        check_word("status", 32'h2, d);
        wait_idle();
    endtask

    task automatic test_four_voice();
        logic [31:0] d;
        int durs [NUM_VOICES] = '{150, 120, 180, 100};
        int vels [NUM_VOICES] = '{127, 100, 64, 33};
        for (int v = 0; v < NUM_VOICES; v++) begin
            write_reg(8'(v * VOICE_STRIDE), $urandom);
            write_reg(8'(v * VOICE_STRIDE + 4), durs[v]);
            write_reg(8'(v * VOICE_STRIDE + 8), vels[v]);
        end
        wait_samples(20);
        read_reg(STATUS_ADDR, d);
        check_word("status", 32'hF, d);
        wait_idle();
    endtask

    task automatic test_bus_errors();
        logic [31:0] d;
        axi_resp_e resp;
        int stall;
        axil_write(8'h0C, 32'hDEAD_BEEF, resp);
        check_value("bresp", SLVERR, resp);
        axil_read(8'h80, d, resp);
        check_value("rresp", SLVERR, resp);
        check_word("rdata", 32'h0, d);
        stall = 2 + int'($urandom % 7);
        start_write(8'h30, 32'hA5A5_0001);
        wait_write_accept();
        start_write(8'h34, 32'h0000_0077);  // Second write while response pending
        repeat (stall) begin
            @(negedge clk);
            assert (!rsp.awready) else begin
                $display("Second write accepted while a write response was pending");
                errors++;
            end
        end
        take_response(0, resp);
        check_value("bresp", OKAY, resp);
        wait_write_accept();
        take_response(int'($urandom % 4), resp);
        check_value("bresp", OKAY, resp);
        read_reg(8'h30, d);
        check_word("tuning3", 32'hA5A5_0001, d);
        read_reg(8'h34, d);
        check_word("duration3", 32'h0000_0077, d);
    endtask

    task automatic test_sample_count();
        logic [31:0] c0, c1;
        int p0, p1;
        wait_samples(1);
        read_reg(COUNT_ADDR, c0);
        p0 = valid_count;
        wait_samples(25);
        read_reg(COUNT_ADDR, c1);
        p1 = valid_count;
        // Count may lead the pulses by the one tick still in flight
        assert (int'(c1 - c0) == p1 - p0 || int'(c1 - c0) == p1 - p0 + 1) else begin
            $display("FAIL t=%0t sample_count delta expected %0d got %0d",
                     $time, p1 - p0, int'(c1 - c0));
            errors++;
        end
    endtask

    // ========================================
    // Main sequence and watchdog
    // ========================================
    initial begin
        void'($urandom(32'h879f6e8d));
        req = '0;
        rst_n = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        test_reset_readback();
        test_single_voice();
        test_note_end();
        test_four_voice();
        test_bus_errors();
        test_sample_count();
        wait_samples(3);
        $display("Errors: %0d, samples compared: %0d", errors, samples_checked);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== verification/synth_tb_sva.sv ====
// Bound protocol checks on the synthesizer bus handshake and audio output
`timescale 1ns/1ns

module synth_tb_sva
    import synth_pkg::*;
(
    input logic                       clk,
    input logic                       rst_n,
    input axil_req_t                  axil_req,
    input axil_rsp_t                  axil_rsp,
    input logic                       sample_tick,
    input logic [NUM_VOICES-1:0]      voice_active,
    input logic                       sample_valid,
    input logic signed [SAMPLE_W-1:0] audio_out
);

    // Responses hold until taken
    bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
        else $error("bvalid dropped before bready");

    rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
        else $error("rvalid dropped before rready");

    valid_single: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid |=> !sample_valid)
        else $error("sample_valid high on two cycles in a row");

    // Silent voices give a silent mix two clocks later
    silent_mix: assert property (@(posedge clk) disable iff (!rst_n)
        sample_tick && voice_active == '0 |-> ##2 (sample_valid && audio_out == '0))
        else $error("audio_out nonzero with all voices idle");

endmodule
